//--- files.f
hdl/vdp_pkg.sv
hdl/vdp_timing.sv
hdl/vdp_spr_linebuf.sv
hdl/vdp_col_mux.sv
hdl/vdp_video_out.sv
verif/vdp_video_out_assertions.sv
verif/vdp_video_out_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module vdp_video_out_tb \
  -f files.f \
  -o vdp_sim

./obj_dir/vdp_sim 2>&1 | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- verif/vdp_testdata.txt
# W vpos plane x col        : sprite write for line vpos, issued on the line before
# C vpos hpos pat col r g b : pixel check with pattern colour, backdrop 4, full palette
W 1 1 5 9
W 1 2 5 3
W 1 3 10 11
C 1 5 2 9 224 96 96
C 1 7 6 6 160 32 32
C 1 8 0 4 32 32 224
C 1 10 2 11 192 192 128
C 1 33 7 4 32 32 224
C 1 35 7 0 0 0 0
W 2 0 12 13
W 2 1 12 2
C 2 12 5 13 192 64 160
C 3 12 5 5 64 96 224
C 3 38 5 4 32 32 224
W 5 2 20 10
W 5 3 20 14
C 5 20 1 10 192 192 32
C 8 3 6 4 32 32 224
C 9 3 6 0 0 0 0
C 11 20 6 4 32 32 224
W 0 0 31 15
C 0 31 3 15 224 224 224
C 0 32 3 4 32 32 224
C 6 16 8 8 224 32 32
C 10 36 0 0 0 0 0

//--- verif/vdp_video_out_tb.sv
`timescale 1ns/1ps

module vdp_video_out_tb import vdp_pkg::*; ();

  localparam int   RESET_CYCLES   = 10;
  // Three frames at three enables in four clocks, plus slack
  localparam int   TIMEOUT_CYCLES = RESET_CYCLES + (3 * H_TOTAL * V_TOTAL * 4) / 3 + 100;
  localparam col_t BACKDROP       = 4'd4;

  logic    clk_i;
  logic    reset_i;
  logic    pix_en_i;
  logic    border_mode_i;
  col_t    reg_col0_i;
  col_t    pat_col_i;
  spr_wr_t spr_wr_i;
  col_t    col_o;
  rgb_t    rgb_o;
  sync_t   sync_o;

  // Reference raster position and expected blanking outputs
  int     m_h;
  int     m_v;
  sync_t  sync_exp;
  logic   last_en;
  int     frame_cnt;
  int     frame_base;
  int     cycle_cnt;
  int     err_cnt;
  int     sync_err_cnt;
  int     test_cnt;
  int     fail_cnt;
  integer seed;

  vdp_video_out #(
    .COMPAT_RGB (0)
  ) u_vdp_video_out (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .pix_en_i      (pix_en_i),
    .border_mode_i (border_mode_i),
    .reg_col0_i    (reg_col0_i),
    .pat_col_i     (pat_col_i),
    .spr_wr_i      (spr_wr_i),
    .col_o         (col_o),
    .rgb_o         (rgb_o),
    .sync_o        (sync_o)
  );

  bind vdp_video_out vdp_video_out_assertions u_vdp_video_out_assertions (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .pix_en_i (pix_en_i),
    .raster_i (raster),
    .col_i    (col_o),
    .rgb_i    (rgb_o),
    .sync_i   (sync_o)
  );

  always #50 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout, run did not end within %0d clock cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Reference model and compare tasks
  // --------------------------------------------------------------------------

  // Blanking outputs for one raster position
  function automatic sync_t expected_sync(input int h, input int v, input logic bmode);
    sync_t s;
    logic  hb;
    logic  vb;
    hb = (h >= H_ACTIVE + H_BORDER_R) && (h < H_ACTIVE + H_BORDER_R + H_BLANK);
    vb = (v >= V_ACTIVE + V_BORDER_B) && (v < V_ACTIVE + V_BORDER_B + V_BLANK);
    s.blank_n = !(hb || vb);
    if (bmode) begin
      s.hblank_n = !hb;
      s.vblank_n = !vb;
    end else begin
      s.hblank_n = (h < H_ACTIVE);
      s.vblank_n = (v < V_ACTIVE);
    end
    return s;
  endfunction

  // About three clocks in four carry the pixel enable
  function automatic logic next_enable();
    return (($random(seed) & 3) != 0);
  endfunction

  task automatic check_col(input col_t actual, input col_t expected);
    if (actual !== expected) begin
      $display("error at %0t: col_o is %0d, expected %0d", $time, actual, expected);
      err_cnt++;
    end
  endtask

  task automatic check_rgb(input rgb_t actual, input rgb_t expected);
    if (actual !== expected) begin
      $display("error at %0t: rgb_o is %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
               actual.r, actual.g, actual.b, expected.r, expected.g, expected.b);
      err_cnt++;
    end
  endtask

  task automatic check_sync(input sync_t actual, input sync_t expected);
    if (actual !== expected) begin
      $display("error at %0t: sync_o is %b, expected %b", $time, actual, expected);
      err_cnt++;
      sync_err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errors);
    test_cnt++;
    if (errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors);
      fail_cnt++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // One clock; model steps with the DUT, then new inputs go out 1 ns later
  task automatic clock_cycle();
    logic bmode;
    @(posedge clk_i);
    last_en = pix_en_i;
    bmode   = border_mode_i;
    if (last_en) begin
      sync_exp = expected_sync(m_h, m_v, bmode);
      if (m_h == H_TOTAL - 1) begin
        m_h = 0;
        m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
      end else begin
        m_h++;
      end
    end
    #1;
    check_sync(sync_o, sync_exp);
    // Frame wrap ends one raster test, next frame flips the border mode
    if (last_en && m_h == 0 && m_v == 0) begin
      report_test($sformatf("raster flags frame %0d border_mode %0d", frame_cnt, bmode),
                  sync_err_cnt - frame_base);
      frame_base = sync_err_cnt;
      frame_cnt++;
      border_mode_i = frame_cnt[0];
    end
    spr_wr_i = '0;
    pix_en_i = next_enable();
  endtask

  task automatic wait_position(input int v, input int h);
    while (!(m_v == v && m_h == h)) begin
      clock_cycle();
    end
  endtask

  // Write goes out after the end-of-line clear of the line before
  task automatic sprite_write(input int v, input int plane, input int x, input int col);
    int pv;
    pv = (v == 0) ? V_TOTAL - 1 : v - 1;
    while (!(m_v == pv && m_h >= H_ACTIVE)) begin
      clock_cycle();
    end
    spr_wr_i.valid = 1'b1;
    spr_wr_i.plane = 2'(plane);
    spr_wr_i.x     = 5'(x);
    spr_wr_i.col   = col_t'(col);
    clock_cycle();
  endtask

  task automatic pixel_check(input int v, input int h, input int pat, input int col,
                             input int r, input int g, input int b);
    int   base;
    rgb_t rgb_exp;
    rgb_exp.r = 8'(r);
    rgb_exp.g = 8'(g);
    rgb_exp.b = 8'(b);
    wait_position(v, h);
    base      = err_cnt;
    pat_col_i = col_t'(pat);
    // col_o settles well before the falling edge
    @(negedge clk_i);
    check_col(col_o, col_t'(col));
    // RGB for this pixel shows after the enable that leaves it
    clock_cycle();
    while (!last_en) begin
      clock_cycle();
    end
    check_rgb(rgb_o, rgb_exp);
    report_test($sformatf("pixel v=%0d h=%0d", v, h), err_cnt - base);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    string line_str;
    byte   kind;
    int    fd;
    int    rc;
    int    base;
    int    v;
    int    h;
    int    plane;
    int    x;
    int    pat;
    int    col;
    int    r;
    int    g;
    int    b;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    pix_en_i      = 1'b0;
    border_mode_i = 1'b0;
    reg_col0_i    = BACKDROP;
    pat_col_i     = '0;
    spr_wr_i      = '0;
    seed          = 32'he25d;
    m_h           = 0;
    m_v           = 0;
    sync_exp      = '0;
    last_en       = 1'b0;
    frame_cnt     = 0;
    frame_base    = 0;
    err_cnt       = 0;
    sync_err_cnt  = 0;
    test_cnt      = 0;
    fail_cnt      = 0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Outputs blanked and black before the first enable
    base = err_cnt;
    check_sync(sync_o, '0);
    check_rgb(rgb_o, '0);
    report_test("reset state", err_cnt - base);
    frame_base = sync_err_cnt;
    pix_en_i   = next_enable();

    fd = $fopen("verif/vdp_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file verif/vdp_testdata.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line_str, fd);
        if (rc > 0) begin
          kind = line_str.getc(0);
          if (kind == "W") begin
            rc = $sscanf(line_str, "W %d %d %d %d", v, plane, x, col);
            sprite_write(v, plane, x, col);
          end else if (kind == "C") begin
            rc = $sscanf(line_str, "C %d %d %d %d %d %d %d", v, h, pat, col, r, g, b);
            pixel_check(v, h, pat, col, r, g, b);
          end
        end
      end
      $fclose(fd);
    end

    // Finish the second frame so both border modes are covered
    while (frame_cnt < 2) begin
      clock_cycle();
    end

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verif/vdp_video_out_assertions.sv
`timescale 1ns/1ps

module vdp_video_out_assertions import vdp_pkg::*; (
  input logic    clk_i,
  input logic    reset_i,
  input logic    pix_en_i,
  input raster_t raster_i,
  input col_t    col_i,
  input rgb_t    rgb_i,
  input sync_t   sync_i
);

  // --------------------------------------------------------------------------
  // Enable gating of the output registers
  // --------------------------------------------------------------------------

  // A clock without pixel enable leaves RGB as it was
  rgb_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    !pix_en_i |=> $stable(rgb_i))
    else $error("rgb_o changed on a clock without pixel enable");

  // Same for the blanking outputs
  sync_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    !pix_en_i |=> $stable(sync_i))
    else $error("sync_o changed on a clock without pixel enable");

  // --------------------------------------------------------------------------
  // Blanking
  // --------------------------------------------------------------------------

  // Colour is black for the whole retrace
  blank_col_a : assert property (@(posedge clk_i) disable iff (reset_i)
    raster_i.blank |-> (col_i == '0))
    else $error("col_o not zero while the raster is in blanking");

endmodule

//--- hdl/vdp_video_out.sv
`timescale 1ns/1ps

module vdp_video_out import vdp_pkg::*; #(
  parameter int COMPAT_RGB = 0
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    pix_en_i,
  input  logic    border_mode_i,
  input  col_t    reg_col0_i,
  input  col_t    pat_col_i,
  input  spr_wr_t spr_wr_i,
  output col_t    col_o,
  output rgb_t    rgb_o,
  output sync_t   sync_o
);

  // Raster position and region flags shared by both consumers
  raster_t   raster;
  // Sprite colours at the current pixel
  spr_cols_t spr_cols;

  // --------------------------------------------------------------------------
  // Raster timing
  // --------------------------------------------------------------------------

  vdp_timing u_vdp_timing (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .pix_en_i (pix_en_i),
    .raster_o (raster)
  );

  // --------------------------------------------------------------------------
  // Sprite line buffer
  // --------------------------------------------------------------------------

  vdp_spr_linebuf u_vdp_spr_linebuf (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pix_en_i   (pix_en_i),
    .raster_i   (raster),
    .spr_wr_i   (spr_wr_i),
    .spr_cols_o (spr_cols)
  );

  // --------------------------------------------------------------------------
  // Colour multiplexer and palette
  // --------------------------------------------------------------------------

  vdp_col_mux #(
    .COMPAT_RGB (COMPAT_RGB)
  ) u_vdp_col_mux (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .pix_en_i      (pix_en_i),
    .border_mode_i (border_mode_i),
    .raster_i      (raster),
    .reg_col0_i    (reg_col0_i),
    .pat_col_i     (pat_col_i),
    .spr_cols_i    (spr_cols),
    .col_o         (col_o),
    .rgb_o         (rgb_o),
    .sync_o        (sync_o)
  );

endmodule

//--- hdl/vdp_col_mux.sv
`timescale 1ns/1ps

module vdp_col_mux import vdp_pkg::*; #(
  parameter int COMPAT_RGB = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      pix_en_i,
  input  logic      border_mode_i,
  input  raster_t   raster_i,
  input  col_t      reg_col0_i,
  input  col_t      pat_col_i,
  input  spr_cols_t spr_cols_i,
  output col_t      col_o,
  output rgb_t      rgb_o,
  output sync_t     sync_o
);

  // --------------------------------------------------------------------------
  // Colour priority
  // --------------------------------------------------------------------------

  logic spr_hit;
  col_t spr_col;
  col_t col_sel;
  rgb_t rgb_lut;

  // First non-transparent plane, lowest index first
  always_comb begin
    spr_hit = 1'b0;
    spr_col = '0;
    for (int i = 0; i < SPR_PLANES; i++) begin
      if (!spr_hit && (spr_cols_i[i] != '0)) begin
        spr_hit = 1'b1;
        spr_col = spr_cols_i[i];
      end
    end
  end

  always_comb begin
    if (raster_i.blank) begin
      // Colour forced black during retrace
      col_sel = '0;
    end else if (!(raster_i.hor_active && raster_i.vert_active)) begin
      // Border shows the backdrop
      col_sel = reg_col0_i;
    end else if (spr_hit) begin
      col_sel = spr_col;
    end else if (pat_col_i != '0) begin
      col_sel = pat_col_i;
    end else begin
      col_sel = reg_col0_i;
    end
  end

  assign col_o = col_sel;

  // Table picked at elaboration
  always_comb begin
    if (COMPAT_RGB == 1) begin
      rgb_lut = COMPAT_RGB_TABLE[col_sel];
    end else begin
      rgb_lut = FULL_RGB_TABLE[col_sel];
    end
  end

  // --------------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------------

  // Result for the pixel being left, one enable behind col_o
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      rgb_o  <= '0;
      sync_o <= '0;
    end else if (pix_en_i) begin
      rgb_o          <= rgb_lut;
      sync_o.blank_n <= !raster_i.blank;
      if (border_mode_i) begin
        // Border counts as visible
        sync_o.hblank_n <= !raster_i.hblank;
        sync_o.vblank_n <= !raster_i.vblank;
      end else begin
        // Only the active window is visible
        sync_o.hblank_n <= raster_i.hor_active;
        sync_o.vblank_n <= raster_i.vert_active;
      end
    end
  end

endmodule

//--- hdl/vdp_spr_linebuf.sv
`timescale 1ns/1ps

module vdp_spr_linebuf import vdp_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      pix_en_i,
  input  raster_t   raster_i,
  input  spr_wr_t   spr_wr_i,
  output spr_cols_t spr_cols_o
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // One colour per plane and active pixel
  col_t line_q [SPR_PLANES][H_ACTIVE];

  logic line_end;

  // Last active pixel is being left on this clock
  assign line_end = pix_en_i && (raster_i.hpos == hpos_t'(H_ACTIVE - 1));

  // Clear has priority over a write on the same clock
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      for (int p = 0; p < SPR_PLANES; p++) begin
        for (int x = 0; x < H_ACTIVE; x++) begin
          line_q[p][x] <= '0;
        end
      end
    end else if (line_end) begin
      // Next line starts all transparent
      for (int p = 0; p < SPR_PLANES; p++) begin
        for (int x = 0; x < H_ACTIVE; x++) begin
          line_q[p][x] <= '0;
        end
      end
    end else if (spr_wr_i.valid) begin
      // Writes are not tied to the pixel enable
      line_q[spr_wr_i.plane][spr_wr_i.x] <= spr_wr_i.col;
    end
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------

  logic [4:0] rd_x;

  // Only the low bits index the line inside the active window
  assign rd_x = raster_i.hpos[4:0];

  // All planes read in parallel at the current pixel
  always_comb begin
    for (int p = 0; p < SPR_PLANES; p++) begin
      if (raster_i.hor_active) begin
        spr_cols_o[p] = line_q[p][rd_x];
      end else begin
        // Transparent outside the active pixels
        spr_cols_o[p] = '0;
      end
    end
  end

endmodule

//--- hdl/vdp_timing.sv
`timescale 1ns/1ps

module vdp_timing import vdp_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    pix_en_i,
  output raster_t raster_o
);

  // --------------------------------------------------------------------------
  // Position counters
  // --------------------------------------------------------------------------

  hpos_t hpos_q;
  vpos_t vpos_q;
  logic  hpos_last;
  logic  vpos_last;

  // Wrap points of the two counters
  assign hpos_last = (hpos_q == hpos_t'(H_TOTAL - 1));
  assign vpos_last = (vpos_q == vpos_t'(V_TOTAL - 1));

  // Pixel counter steps on every enable
  // Line counter steps when the pixel counter wraps
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      hpos_q <= '0;
      vpos_q <= '0;
    end else if (pix_en_i) begin
      if (hpos_last) begin
        hpos_q <= '0;
        if (vpos_last) begin
          vpos_q <= '0;
        end else begin
          vpos_q <= vpos_q + 1'b1;
        end
      end else begin
        hpos_q <= hpos_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Region decode
  // --------------------------------------------------------------------------

  logic hblank;
  logic vblank;

  // Blanking sits between the right border and the left border
  assign hblank = (hpos_q >= hpos_t'(H_ACTIVE + H_BORDER_R)) &&
                  (hpos_q <  hpos_t'(H_ACTIVE + H_BORDER_R + H_BLANK));

  // Vertical blanking sits between bottom and top border
  assign vblank = (vpos_q >= vpos_t'(V_ACTIVE + V_BORDER_B)) &&
                  (vpos_q <  vpos_t'(V_ACTIVE + V_BORDER_B + V_BLANK));

  // Pack counters and flags for the consumers
  always_comb begin
    raster_o.hpos        = hpos_q;
    raster_o.vpos        = vpos_q;
    raster_o.hor_active  = (hpos_q < hpos_t'(H_ACTIVE));
    raster_o.vert_active = (vpos_q < vpos_t'(V_ACTIVE));
    raster_o.hblank      = hblank;
    raster_o.vblank      = vblank;
    raster_o.blank       = hblank | vblank;
  end

endmodule

//--- hdl/vdp_pkg.sv
package vdp_pkg;

  // --------------------------------------------------------------------------
  // Frame geometry
  // --------------------------------------------------------------------------

  // Horizontal regions in pixels, left to right from the first active pixel
  localparam int H_ACTIVE   = 32;
  localparam int H_BORDER_R = 2;
  localparam int H_BLANK    = 4;
  localparam int H_BORDER_L = 2;
  localparam int H_TOTAL    = H_ACTIVE + H_BORDER_R + H_BLANK + H_BORDER_L;

  // Vertical regions in lines, top to bottom from the first active line
  localparam int V_ACTIVE   = 8;
  localparam int V_BORDER_B = 1;
  localparam int V_BLANK    = 2;
  localparam int V_BORDER_T = 1;
  localparam int V_TOTAL    = V_ACTIVE + V_BORDER_B + V_BLANK + V_BORDER_T;

  localparam int SPR_PLANES = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Palette index where 0 is transparent for sprites and pattern
  typedef logic [3:0] col_t;
  typedef logic [5:0] hpos_t;
  typedef logic [3:0] vpos_t;

  typedef struct packed {
    hpos_t hpos;
    vpos_t vpos;
    logic  hor_active;
    logic  vert_active;
    logic  blank;
    logic  hblank;
    logic  vblank;
  } raster_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] plane;
    logic [4:0] x;
    col_t       col;
  } spr_wr_t;

  // Plane 0 wins over the others
  typedef col_t [SPR_PLANES-1:0] spr_cols_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // All active low, so zero means fully blanked
  typedef struct packed {
    logic blank_n;
    logic hblank_n;
    logic vblank_n;
  } sync_t;

  // --------------------------------------------------------------------------
  // Palettes
  // --------------------------------------------------------------------------

  // Full range colours
  localparam rgb_t FULL_RGB_TABLE [16] = '{
    '{8'd0,   8'd0,   8'd0},   '{8'd0,   8'd0,   8'd0},
    '{8'd32,  8'd192, 8'd32},  '{8'd96,  8'd224, 8'd96},
    '{8'd32,  8'd32,  8'd224}, '{8'd64,  8'd96,  8'd224},
    '{8'd160, 8'd32,  8'd32},  '{8'd64,  8'd192, 8'd224},
    '{8'd224, 8'd32,  8'd32},  '{8'd224, 8'd96,  8'd96},
    '{8'd192, 8'd192, 8'd32},  '{8'd192, 8'd192, 8'd128},
    '{8'd32,  8'd128, 8'd32},  '{8'd192, 8'd64,  8'd160},
    '{8'd160, 8'd160, 8'd160}, '{8'd224, 8'd224, 8'd224}
  };

  // Softer colours as seen on a composite monitor
  localparam rgb_t COMPAT_RGB_TABLE [16] = '{
    '{8'd0,   8'd0,   8'd0},   '{8'd0,   8'd0,   8'd0},
    '{8'd33,  8'd200, 8'd66},  '{8'd94,  8'd220, 8'd120},
    '{8'd84,  8'd85,  8'd237}, '{8'd125, 8'd118, 8'd252},
    '{8'd212, 8'd82,  8'd77},  '{8'd66,  8'd235, 8'd245},
    '{8'd252, 8'd85,  8'd84},  '{8'd255, 8'd121, 8'd120},
    '{8'd212, 8'd193, 8'd84},  '{8'd230, 8'd206, 8'd128},
    '{8'd33,  8'd176, 8'd59},  '{8'd201, 8'd91,  8'd186},
    '{8'd204, 8'd204, 8'd204}, '{8'd255, 8'd255, 8'd255}
  };

endpackage
